// ==== list.f ====
logic/apb_bus_pkg.sv
logic/periph_map_pkg.sv
logic/apb2iob_bridge.sv
logic/iob_bank_split.sv
logic/scratch_bank.sv
logic/iob_rdata_merge.sv
logic/apb_periph_top.sv
test/apb_periph_sva.sv
test/periph_checker.sv
test/tb_apb_periph.sv

// ==== logic/apb2iob_bridge.sv ====
// APB slave to IOb master bridge
// Four-state program counter, registered pready, captured read word

module apb2iob_bridge (
   input  logic                          clk_i,
   input  logic                          rst_n_i,
   input  apb_bus_pkg::apb_req_t         apb_req_i,
   output logic                          apb_ready_o,
   output logic [apb_bus_pkg::DATA_W-1:0] apb_rdata_o,
   output apb_bus_pkg::iob_req_t         iob_req_o,
   input  apb_bus_pkg::iob_rsp_t         iob_rsp_i
);
   import apb_bus_pkg::*;

   typedef enum logic [1:0] {
      WAIT_ENABLE    = 2'd0,
      WAIT_READY     = 2'd1,
      WAIT_RVALID    = 2'd2,
      WAIT_APB_READY = 2'd3
   } pc_t;

   pc_t  pc_q;
   pc_t  pc_d;
   logic iob_valid;
   logic apb_ready_d;

   // Address and data pass straight through from the APB request
   assign iob_req_o.valid = iob_valid;
   assign iob_req_o.addr  = apb_req_i.addr;
   assign iob_req_o.wdata = apb_req_i.wdata;
   assign iob_req_o.wstrb = apb_req_i.write ? apb_req_i.wstrb : {WSTRB_W{1'b0}};

   // Program counter next state
   always_comb begin
      pc_d        = pc_q;
      iob_valid   = 1'b0;
      apb_ready_d = 1'b0;

      case (pc_q)
         WAIT_ENABLE: begin
            if (apb_req_i.sel && apb_req_i.enable) begin
               pc_d = WAIT_READY;  // Valid goes out next cycle
            end
         end
         WAIT_READY: begin
            iob_valid = 1'b1;
            if (iob_rsp_i.ready) begin
               if (apb_req_i.write) begin
                  pc_d        = WAIT_APB_READY;
                  apb_ready_d = 1'b1;  // Write done on acceptance
               end else begin
                  pc_d = WAIT_RVALID;
               end
            end
         end
         WAIT_RVALID: begin
            if (iob_rsp_i.rvalid) begin
               pc_d        = WAIT_APB_READY;
               apb_ready_d = 1'b1;  // Word captured this edge
            end
         end
         default: begin
            // Pready high this cycle, master moves on
            pc_d = WAIT_ENABLE;
         end
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         pc_q        <= WAIT_ENABLE;
         apb_ready_o <= 1'b0;
      end else begin
         pc_q        <= pc_d;
         apb_ready_o <= apb_ready_d;
      end
   end

   // Read word, held until the next read response
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         apb_rdata_o <= {DATA_W{1'b0}};
      end else if (iob_rsp_i.rvalid) begin
         apb_rdata_o <= iob_rsp_i.rdata;
      end
   end

endmodule

// ==== logic/apb_bus_pkg.sv ====
// Bus widths shared by the APB port and the internal IOb links
// Packed request and response structs for both buses

package apb_bus_pkg;

   localparam int APB_ADDR_W = 12;         // Byte address
   localparam int DATA_W     = 32;
   localparam int WSTRB_W    = DATA_W / 8; // One strobe per byte

   // APB request as driven by the master
   typedef struct packed {
      logic                  sel;
      logic                  enable;
      logic                  write;
      logic [APB_ADDR_W-1:0] addr;
      logic [DATA_W-1:0]     wdata;
      logic [WSTRB_W-1:0]    wstrb;
   } apb_req_t;

   // IOb request, all strobes low means a read
   typedef struct packed {
      logic                  valid;
      logic [APB_ADDR_W-1:0] addr;
      logic [DATA_W-1:0]     wdata;
      logic [WSTRB_W-1:0]    wstrb;
   } iob_req_t;

   // IOb response, rvalid one cycle after a read is accepted
   typedef struct packed {
      logic              ready;
      logic              rvalid;
      logic [DATA_W-1:0] rdata;
   } iob_rsp_t;

endpackage

// ==== logic/apb_periph_top.sv ====
// Top level of the APB scratch register subsystem
// Bridge, address splitter, generated banks and response merger

module apb_periph_top (
   input  logic                           clk_i,
   input  logic                           rst_n_i,
   input  apb_bus_pkg::apb_req_t          apb_req_i,
   output logic                           apb_ready_o,
   output logic [apb_bus_pkg::DATA_W-1:0] apb_rdata_o
);
   import apb_bus_pkg::*;
   import periph_map_pkg::*;

   iob_req_t               bridge_req;
   iob_rsp_t               merged_rsp;
   iob_req_t [N_BANKS-1:0] bank_req;
   iob_rsp_t [N_BANKS-1:0] bank_rsp;
   iob_rsp_t               miss_rsp;

   apb2iob_bridge u_bridge (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .apb_req_i  (apb_req_i),
      .apb_ready_o(apb_ready_o),
      .apb_rdata_o(apb_rdata_o),
      .iob_req_o  (bridge_req),
      .iob_rsp_i  (merged_rsp)
   );

   iob_bank_split u_split (
      .clk_i     (clk_i),
      .rst_n_i   (rst_n_i),
      .iob_req_i (bridge_req),
      .bank_req_o(bank_req),
      .miss_rsp_o(miss_rsp)
   );

   // One scratch bank per address slot
   for (genvar b = 0; b < N_BANKS; b++) begin : g_bank
      scratch_bank u_bank (
         .clk_i    (clk_i),
         .rst_n_i  (rst_n_i),
         .iob_req_i(bank_req[b]),
         .iob_rsp_o(bank_rsp[b])
      );
   end

   iob_rdata_merge u_merge (
      .bank_rsp_i(bank_rsp),
      .miss_rsp_i(miss_rsp),
      .iob_rsp_o (merged_rsp)
   );

endmodule

// ==== logic/iob_bank_split.sv ====
// IOb address decoder for the scratch banks
// Routes valid to the addressed bank, answers out-of-map accesses

module iob_bank_split (
   input  logic                                                   clk_i,
   input  logic                                                   rst_n_i,
   input  apb_bus_pkg::iob_req_t                                  iob_req_i,
   output apb_bus_pkg::iob_req_t [periph_map_pkg::N_BANKS-1:0] bank_req_o,
   output apb_bus_pkg::iob_rsp_t                                  miss_rsp_o
);
   import apb_bus_pkg::*;
   import periph_map_pkg::*;

   logic [BANK_IDX_W-1:0] bank_idx;
   logic                  in_map;
   logic                  miss_read;
   logic                  miss_rvalid_q;

   assign bank_idx = iob_req_i.addr[BANK_BASE_BIT +: BANK_IDX_W];

   // Upper address bits all zero
   assign in_map = ~|iob_req_i.addr[APB_ADDR_W-1:MAP_TOP_BIT];

   // Every bank sees the payload, only one sees valid
   always_comb begin
      for (int b = 0; b < N_BANKS; b++) begin
         bank_req_o[b]       = iob_req_i;
         bank_req_o[b].valid = iob_req_i.valid && in_map &&
                               (bank_idx == BANK_IDX_W'(b));
      end
   end

   // Out-of-map read, no strobes set
   assign miss_read = iob_req_i.valid && !in_map && (iob_req_i.wstrb == '0);

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         miss_rvalid_q <= 1'b0;
      end else begin
         miss_rvalid_q <= miss_read;
      end
   end

   // Writes dropped, reads answered with zero
   assign miss_rsp_o.ready  = iob_req_i.valid && !in_map;  // Same-cycle ack
   assign miss_rsp_o.rvalid = miss_rvalid_q;
   assign miss_rsp_o.rdata  = {DATA_W{1'b0}};

endmodule

// ==== logic/iob_rdata_merge.sv ====
// Merges the bank and out-of-map responses into one IOb response
// At most one source drives rvalid in any cycle

module iob_rdata_merge (
   input  apb_bus_pkg::iob_rsp_t [periph_map_pkg::N_BANKS-1:0] bank_rsp_i,
   input  apb_bus_pkg::iob_rsp_t                                  miss_rsp_i,
   output apb_bus_pkg::iob_rsp_t                                  iob_rsp_o
);
   import apb_bus_pkg::*;
   import periph_map_pkg::*;

   logic              ready_or;
   logic              rvalid_or;
   logic [DATA_W-1:0] rdata_or;

   always_comb begin
      ready_or  = miss_rsp_i.ready;
      rvalid_or = miss_rsp_i.rvalid;
      rdata_or  = miss_rsp_i.rvalid ? miss_rsp_i.rdata : {DATA_W{1'b0}};

      for (int b = 0; b < N_BANKS; b++) begin
         ready_or  = ready_or | bank_rsp_i[b].ready;
         rvalid_or = rvalid_or | bank_rsp_i[b].rvalid;
         if (bank_rsp_i[b].rvalid) begin
            rdata_or = rdata_or | bank_rsp_i[b].rdata;  // Gated by own rvalid
         end
      end
   end

   assign iob_rsp_o.ready  = ready_or;
   assign iob_rsp_o.rvalid = rvalid_or;
   assign iob_rsp_o.rdata  = rdata_or;

endmodule

// ==== logic/periph_map_pkg.sv ====
// Address map of the scratch register banks
// Bank count, bank size and address field positions

package periph_map_pkg;

   localparam int N_BANKS       = 4;
   localparam int REGS_PER_BANK = 8;

   localparam int REG_IDX_W  = $clog2(REGS_PER_BANK);
   localparam int BANK_IDX_W = $clog2(N_BANKS);

   // Byte offset in bits 1:0, register index in bits 4:2
   localparam int BANK_BASE_BIT = 5;

   // First address bit above the bank field
   // All bits from here up must be zero for an in-map access
   localparam int MAP_TOP_BIT = BANK_BASE_BIT + BANK_IDX_W;

endpackage

// ==== logic/scratch_bank.sv ====
// One bank of byte-writable scratch registers on IOb
// Same-cycle ready, read data registered one cycle after acceptance

module scratch_bank (
   input  logic                  clk_i,
   input  logic                  rst_n_i,
   input  apb_bus_pkg::iob_req_t iob_req_i,
   output apb_bus_pkg::iob_rsp_t iob_rsp_o
);
   import apb_bus_pkg::*;
   import periph_map_pkg::*;

   logic [DATA_W-1:0]    regs_q [REGS_PER_BANK];
   logic [REG_IDX_W-1:0] reg_idx;
   logic                 wr_en;
   logic                 rd_en;
   logic                 rvalid_q;
   logic [DATA_W-1:0]    rdata_q;

   // Register index sits just below the bank field
   assign reg_idx = iob_req_i.addr[BANK_BASE_BIT-1 -: REG_IDX_W];

   assign wr_en = iob_req_i.valid && (iob_req_i.wstrb != '0);
   assign rd_en = iob_req_i.valid && (iob_req_i.wstrb == '0);

   // Byte-strobed write
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         for (int r = 0; r < REGS_PER_BANK; r++) begin
            regs_q[r] <= {DATA_W{1'b0}};
         end
      end else if (wr_en) begin
         for (int i = 0; i < WSTRB_W; i++) begin
            if (iob_req_i.wstrb[i]) begin
               regs_q[reg_idx][8*i +: 8] <= iob_req_i.wdata[8*i +: 8];
            end
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         rvalid_q <= 1'b0;
      end else begin
         rvalid_q <= rd_en;
      end
   end

   // Read word, only meaningful while rvalid is high
   always_ff @(posedge clk_i) begin
      if (rd_en) begin
         rdata_q <= regs_q[reg_idx];
      end
   end

   assign iob_rsp_o.ready  = iob_req_i.valid;  // Never stalls
   assign iob_rsp_o.rvalid = rvalid_q;
   assign iob_rsp_o.rdata  = rdata_q;

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Builds the APB scratch register testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

LOG=sim.log
FAIL_MSG="Test failures found"

verilator --binary --timing --assert -j 0 \
   --top-module tb_apb_periph -f list.f -o sim_tb
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/sim_tb +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "$FAIL_MSG" "$LOG"; then
   echo "Simulation FAILED"
   exit 1
fi

echo "Simulation PASSED"
exit 0

// ==== test/apb_periph_sva.sv ====
// Protocol assertions for the APB to IOb bridge
// Bound into every apb2iob_bridge instance

module apb_periph_sva (
   input logic                  clk_i,
   input logic                  rst_n_i,
   input apb_bus_pkg::apb_req_t apb_req_i,
   input logic                  apb_ready_i,
   input apb_bus_pkg::iob_req_t iob_req_i,
   input apb_bus_pkg::iob_rsp_t iob_rsp_i
);
   import apb_bus_pkg::*;

   int unsigned fail_count = 0;

   // Valid holds until the slave takes it and drops right after
   valid_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      iob_req_i.valid |=> iob_req_i.valid == !$past(iob_rsp_i.ready))
      else begin
         fail_count++;
         $error("IOb valid not held until acceptance or not dropped after it");
      end

   ready_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      apb_ready_i |=> !apb_ready_i)
      else begin
         fail_count++;
         $error("APB ready held high for more than one cycle");
      end

   ready_in_access: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      apb_ready_i |-> apb_req_i.sel && apb_req_i.enable)
      else begin
         fail_count++;
         $error("APB ready outside the access phase");
      end

   // Idle bridge issues nothing
   no_idle_valid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      iob_req_i.valid |-> apb_req_i.sel && apb_req_i.enable)
      else begin
         fail_count++;
         $error("IOb valid issued with no APB transfer in progress");
      end

endmodule

bind apb2iob_bridge apb_periph_sva u_sva (
   .clk_i      (clk_i),
   .rst_n_i    (rst_n_i),
   .apb_req_i  (apb_req_i),
   .apb_ready_i(apb_ready_o),
   .iob_req_i  (iob_req_o),
   .iob_rsp_i  (iob_rsp_i)
);

// ==== test/periph_checker.sv ====
// Compares APB read data with expected words from the reference model
// Also counts APB ready pulses

module periph_checker (
   input  logic                           clk_i,
   input  logic                           rst_n_i,
   input  apb_bus_pkg::apb_req_t          apb_req_i,
   input  logic                           apb_ready_i,
   input  logic [apb_bus_pkg::DATA_W-1:0] apb_rdata_i,
   input  logic                           exp_push_i,
   input  logic [apb_bus_pkg::DATA_W-1:0] exp_word_i,
   input  logic [2:0]                     test_id_i,
   output int unsigned                    err_count_o,
   output int unsigned                    ready_count_o
);
   import apb_bus_pkg::*;

   logic [DATA_W-1:0] exp_q [$];  // Expected read words in issue order
   logic [DATA_W-1:0] expected;
   int unsigned       err_count   = 0;
   int unsigned       ready_count = 0;

   function automatic string test_name(input logic [2:0] id);
      case (id)
         3'd1:    return "reset_values";
         3'd2:    return "full_words";
         3'd3:    return "byte_strobes";
         3'd4:    return "out_of_map";
         3'd5:    return "random";
         default: return "unknown";
      endcase
   endfunction

   // Mid-cycle sampling, inputs and outputs are settled here
   always @(negedge clk_i) begin
      if (rst_n_i) begin
         if (exp_push_i) begin
            exp_q.push_back(exp_word_i);
         end
         if (apb_ready_i) begin
            ready_count++;
            if (!apb_req_i.write) begin
               if (exp_q.size() == 0) begin
                  $display("APB read completed with no expected word from the reference model");
                  err_count++;
               end else begin
                  expected = exp_q.pop_front();
                  if (apb_rdata_i !== expected) begin
                     $display("CHECK FAILED %s: addr %03h expected %08h, actual %08h",
                              test_name(test_id_i), apb_req_i.addr, expected, apb_rdata_i);
                     err_count++;
                  end
               end
            end
         end
      end
   end

   assign err_count_o   = err_count;
   assign ready_count_o = ready_count;

endmodule

// ==== test/tb_apb_periph.sv ====
// Testbench for the APB scratch register subsystem
// Clock, reset, APB driver, reference model and watchdog

module tb_apb_periph;
   import apb_bus_pkg::*;
   import periph_map_pkg::*;

   localparam int CLK_PERIOD = 10;
   localparam int RST_CYCLES = 16;
   localparam int N_REGS     = N_BANKS * REGS_PER_BANK;
   localparam int N_STROBE   = 8;
   localparam int N_MISS     = 4;
   localparam int N_RANDOM   = 300;
   // Reset reads, fill and readback, strobe triples, miss pairs, readback, random
   localparam int N_XFERS = N_REGS + 2 * N_REGS + 3 * N_STROBE + 2 * N_MISS + N_REGS + N_RANDOM;

   logic              clk;
   logic              rst_n;
   apb_req_t          apb_req;
   logic              apb_ready;
   logic [DATA_W-1:0] apb_rdata;
   logic              exp_push;
   logic [DATA_W-1:0] exp_word;
   logic [2:0]        test_id;
   int unsigned       data_errs;
   int unsigned       ready_count;
   int unsigned       issued;
   int unsigned       pulse_errs;
   int unsigned       sva_errs;
   logic [DATA_W-1:0] shadow [N_REGS];  // Expected contents of all banks

   apb_periph_top i_dut (
      .clk_i      (clk),
      .rst_n_i    (rst_n),
      .apb_req_i  (apb_req),
      .apb_ready_o(apb_ready),
      .apb_rdata_o(apb_rdata)
   );

   periph_checker u_checker (
      .clk_i        (clk),
      .rst_n_i      (rst_n),
      .apb_req_i    (apb_req),
      .apb_ready_i  (apb_ready),
      .apb_rdata_i  (apb_rdata),
      .exp_push_i   (exp_push),
      .exp_word_i   (exp_word),
      .test_id_i    (test_id),
      .err_count_o  (data_errs),
      .ready_count_o(ready_count)
   );

   initial clk = 1'b0;
   always #(CLK_PERIOD / 2) clk = ~clk;

   // Applies a write to the shadow, returns the expected read word
   function automatic logic [DATA_W-1:0] ref_access(input logic [APB_ADDR_W-1:0] addr,
                                                    input logic write,
                                                    input logic [DATA_W-1:0] wdata,
                                                    input logic [WSTRB_W-1:0] wstrb);
      int                idx;
      logic [DATA_W-1:0] word;
      if (addr[APB_ADDR_W-1:MAP_TOP_BIT] != '0) begin
         return '0;  // Outside the map
      end
      idx  = int'(addr[BANK_BASE_BIT +: BANK_IDX_W]) * REGS_PER_BANK
           + int'(addr[BANK_BASE_BIT-1 -: REG_IDX_W]);
      word = shadow[idx];
      if (write) begin
         for (int i = 0; i < WSTRB_W; i++) begin
            if (wstrb[i]) word[8*i +: 8] = wdata[8*i +: 8];
         end
         shadow[idx] = word;
      end
      return word;
   endfunction

   function automatic logic [APB_ADDR_W-1:0] reg_addr(input int idx);
      int bank;
      int regn;
      bank = idx / REGS_PER_BANK;
      regn = idx % REGS_PER_BANK;
      return APB_ADDR_W'((bank << BANK_BASE_BIT) + (regn << 2));
   endfunction

   function automatic logic [APB_ADDR_W-1:0] miss_addr();
      logic [APB_ADDR_W-1:0] a;
      a = APB_ADDR_W'($urandom);
      a[APB_ADDR_W-1] = 1'b1;  // Top bit forces a miss
      return a;
   endfunction

   // One APB transfer, setup then access phase until ready
   task automatic apb_xfer(input logic [APB_ADDR_W-1:0] addr, input logic write,
                           input logic [DATA_W-1:0] wdata, input logic [WSTRB_W-1:0] wstrb);
      logic [DATA_W-1:0] expected;
      expected = ref_access(addr, write, wdata, wstrb);
      @(posedge clk);
      #1;
      apb_req.sel    = 1'b1;
      apb_req.enable = 1'b0;
      apb_req.write  = write;
      apb_req.addr   = addr;
      apb_req.wdata  = wdata;
      apb_req.wstrb  = wstrb;
      exp_push       = !write;
      exp_word       = expected;
      @(posedge clk);
      #1;
      apb_req.enable = 1'b1;
      exp_push       = 1'b0;
      @(negedge clk);
      while (!apb_ready) @(negedge clk);
      @(posedge clk);
      #1;
      apb_req.sel    = 1'b0;
      apb_req.enable = 1'b0;
      issued++;
   endtask

   task automatic read_all();
      for (int i = 0; i < N_REGS; i++) apb_xfer(reg_addr(i), 1'b0, '0, '0);
   endtask

   task automatic check_strobes();
      int idx;
      test_id = 3'd3;
      for (int k = 0; k < N_STROBE; k++) begin
         idx = int'($urandom_range(N_REGS - 1));
         apb_xfer(reg_addr(idx), 1'b1, $urandom, 4'hf);
         apb_xfer(reg_addr(idx), 1'b1, $urandom, WSTRB_W'($urandom_range(14, 1)));
         apb_xfer(reg_addr(idx), 1'b0, '0, '0);
      end
   endtask

   task automatic check_random();
      logic [APB_ADDR_W-1:0] addr;
      test_id = 3'd5;
      for (int n = 0; n < N_RANDOM; n++) begin
         if ($urandom_range(7) == 0) addr = miss_addr();
         else addr = reg_addr(int'($urandom_range(N_REGS - 1)));
         if ($urandom_range(1) == 1) begin
            apb_xfer(addr, 1'b1, $urandom, WSTRB_W'($urandom_range(15, 1)));
         end else begin
            apb_xfer(addr, 1'b0, '0, '0);
         end
      end
   endtask

   initial begin
      void'($urandom(32'hb690_50cb));
      apb_req    = '0;
      exp_push   = 1'b0;
      exp_word   = '0;
      test_id    = 3'd0;
      issued     = 0;
      pulse_errs = 0;
      rst_n      = 1'b0;
      for (int i = 0; i < N_REGS; i++) shadow[i] = '0;
      repeat (RST_CYCLES) @(posedge clk);
      #1 rst_n = 1'b1;

      test_id = 3'd1;
      read_all();
      test_id = 3'd2;
      for (int i = 0; i < N_REGS; i++) apb_xfer(reg_addr(i), 1'b1, $urandom, 4'hf);
      read_all();
      check_strobes();
      test_id = 3'd4;
      for (int k = 0; k < N_MISS; k++) begin
         apb_xfer(miss_addr(), 1'b1, $urandom, 4'hf);
         apb_xfer(miss_addr(), 1'b0, '0, '0);
      end
      read_all();  // In-map words untouched by the misses
      check_random();

      repeat (4) @(posedge clk);
      if (ready_count != issued) begin
         $display("CHECK FAILED pulse_count: expected %0d, actual %0d", issued, ready_count);
         pulse_errs++;
      end
      sva_errs = i_dut.u_bridge.u_sva.fail_count;
      $display("Error counts: data %0d, pulse count %0d, assertions %0d",
               data_errs, pulse_errs, sva_errs);
      if (data_errs + pulse_errs + sva_errs == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

   // Ten cycles per transfer is far above the read latency
   initial begin
      #((N_XFERS * 10 + RST_CYCLES) * CLK_PERIOD);
      $display("Watchdog expired before all transfers completed");
      $display("Test failures found");
      $finish;
   end

endmodule
